// File: src/rsPkg.sv
package rsPkg;

    localparam int XLEN        = 32;
    localparam int ROB_ENTRIES = 16;
    localparam int ROB_TAG_W   = 4;
    localparam int RS_ENTRIES  = 8;
    localparam int RS_IDX_W    = 3;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [ROB_TAG_W-1:0] robTag_t;

    // Integer ops held by the station
    typedef enum logic [4:0] {
        opAdd, opSub, opAnd, opOr, opXor,
        opSll, opSrl, opSra, opSlt, opSltu,
        opAddi, opAndi, opOri, opXori,
        opSlli, opSrli, opSrai, opSlti, opSltiu,
        opLui
    } rsOp_t;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSll,
        aluSrl,
        aluSra,
        aluSlt,
        aluSltu
    } aluOp_t;

    typedef struct packed {
        rsOp_t   op;
        word_t   vj;
        word_t   vk;
        word_t   imm;
        robTag_t qj;
        robTag_t qk;
        logic    qjWait;   // vj not yet produced
        logic    qkWait;
        logic    useImm;   // Right operand comes from imm
        robTag_t tag;      // Destination ROB slot
    } rsEntry_t;

endpackage

// File: src/rsIf.sv
`timescale 1ns/1ns

// Dispatch register to entry bank
interface dispatchIf;
    import rsPkg::*;

    logic     valid;
    rsEntry_t entry;
    logic     full;

    modport producer (
        output valid,
        output entry,
        input  full
    );

    modport buffer (
        input  valid,
        input  entry,
        output full
    );
endinterface

// Entry bank to issue stage, no stall
interface issueIf;
    import rsPkg::*;

    logic     valid;
    rsEntry_t entry;

    modport buffer (output valid, output entry);
    modport consumer (input valid, input entry);
endinterface

// File: src/rsDispatch.sv
`timescale 1ns/1ns

module rsDispatch (
    input  logic            clk,
    input  logic            rst,
    input  logic            clr,
    input  logic            dispValid,
    input  rsPkg::rsOp_t    dispOp,
    input  rsPkg::word_t    dispVj,
    input  rsPkg::word_t    dispVk,
    input  rsPkg::word_t    dispImm,
    input  rsPkg::robTag_t  dispQj,
    input  rsPkg::robTag_t  dispQk,
    input  rsPkg::robTag_t  dispTag,
    input  logic            dispQjWait,
    input  logic            dispQkWait,
    output logic            dispAccept,
    dispatchIf.producer     disp
);
    import rsPkg::*;

    logic     regValid;
    rsEntry_t regEntry;
    rsEntry_t newEntry;
    logic     isImm;
    logic     isLui;

    assign isLui = (dispOp == opLui);
    assign isImm = dispOp inside {opAddi, opAndi, opOri, opXori, opSlli,
                                  opSrli, opSrai, opSlti, opSltiu, opLui};

    always_comb begin
        newEntry.op     = dispOp;
        newEntry.vj     = dispVj;
        newEntry.vk     = dispVk;
        newEntry.imm    = dispImm;
        newEntry.qj     = dispQj;
        newEntry.qk     = dispQk;
        newEntry.qjWait = dispQjWait && !isLui;  // LUI reads no register
        newEntry.qkWait = dispQkWait && !isImm;
        newEntry.useImm = isImm;
        newEntry.tag    = dispTag;
    end

    // Free slot now, or the bank drains it this edge
    assign dispAccept = !regValid || !disp.full;

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            regValid <= 1'b0;
        end else if (dispValid && dispAccept) begin
            regValid <= 1'b1;
        end else if (!disp.full) begin
            regValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dispValid && dispAccept) begin
            regEntry <= newEntry;
        end
    end

    assign disp.valid = regValid;
    assign disp.entry = regEntry;

    // Source must hold a stalled request
    assert property (@(posedge clk) disable iff (rst || clr)
        dispValid && !dispAccept |=> dispValid && $stable({dispOp, dispVj, dispVk,
            dispImm, dispQj, dispQk, dispTag, dispQjWait, dispQkWait}));

endmodule

// File: src/rsEntryBank.sv
`timescale 1ns/1ns

module rsEntryBank (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          clr,
    input  logic [rsPkg::ROB_ENTRIES-1:0]                 robValid,
    input  rsPkg::word_t [rsPkg::ROB_ENTRIES-1:0]         robValue,
    dispatchIf.buffer                                     disp,
    issueIf.buffer                                        issue
);
    import rsPkg::*;

    rsEntry_t              slot [RS_ENTRIES];
    logic [RS_ENTRIES-1:0] busy;
    logic [RS_ENTRIES-1:0] ready;
    logic [RS_ENTRIES-1:0] wrMask;
    logic [RS_ENTRIES-1:0] issueMask;
    logic [RS_IDX_W-1:0]   freeIdx;
    logic [RS_IDX_W-1:0]   issueIdx;
    logic                  wrEn;

    // Pick up finished operands from the ROB
    function automatic rsEntry_t wake(rsEntry_t e);
        rsEntry_t w;
        w = e;
        if (w.qjWait && robValid[w.qj]) begin
            w.vj     = robValue[w.qj];
            w.qjWait = 1'b0;
        end
        if (w.qkWait && robValid[w.qk]) begin
            w.vk     = robValue[w.qk];
            w.qkWait = 1'b0;
        end
        return w;
    endfunction

    always_comb begin
        for (int i = 0; i < RS_ENTRIES; i++) begin
            ready[i] = busy[i] && !slot[i].qjWait && !slot[i].qkWait;
        end
    end

    // Lowest index wins for both searches
    always_comb begin
        freeIdx  = '0;
        issueIdx = '0;
        for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                freeIdx = RS_IDX_W'(i);
            end
            if (ready[i]) begin
                issueIdx = RS_IDX_W'(i);
            end
        end
    end

    assign disp.full   = &busy;
    assign wrEn        = disp.valid && !disp.full;
    assign wrMask      = wrEn ? (RS_ENTRIES'(1) << freeIdx) : '0;

    assign issue.valid = |ready;
    assign issue.entry = slot[issueIdx];
    assign issueMask   = issue.valid ? (RS_ENTRIES'(1) << issueIdx) : '0;

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~issueMask) | wrMask;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_ENTRIES; i++) begin
            if (wrMask[i]) begin
                slot[i] <= wake(disp.entry);  // Wakeup on the write edge too
            end else begin
                slot[i] <= wake(slot[i]);
            end
        end
    end

    // Written slot holds its entry afterwards
    assert property (@(posedge clk) disable iff (rst || clr)
        wrEn |=> busy[$past(freeIdx)]);

    // Issued slot is released on the issue edge
    assert property (@(posedge clk) disable iff (rst || clr)
        issue.valid |=> !busy[$past(issueIdx)]);

endmodule

// File: src/rsIssueAlu.sv
`timescale 1ns/1ns

module rsIssueAlu (
    input  logic            clk,
    input  logic            rst,
    input  logic            clr,
    issueIf.consumer        issue,
    output logic            wbValid,
    output rsPkg::robTag_t  wbTag,
    output rsPkg::word_t    wbValue
);
    import rsPkg::*;

    logic    s1Valid;
    aluOp_t  s1Op;
    word_t   s1A;
    word_t   s1B;
    robTag_t s1Tag;
    word_t   aluResult;
    logic [4:0] shamt;

    function automatic aluOp_t toAluOp(rsOp_t op);
        case (op)
            opSub:          return aluSub;
            opAnd, opAndi:  return aluAnd;
            opOr, opOri:    return aluOr;
            opXor, opXori:  return aluXor;
            opSll, opSlli:  return aluSll;
            opSrl, opSrli:  return aluSrl;
            opSra, opSrai:  return aluSra;
            opSlt, opSlti:  return aluSlt;
            opSltu, opSltiu: return aluSltu;
            default:        return aluAdd;  // ADD, ADDI, LUI
        endcase
    endfunction

    // Issue register
    always_ff @(posedge clk) begin
        if (rst || clr) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Op  <= toAluOp(issue.entry.op);
        s1A   <= (issue.entry.op == opLui) ? '0 : issue.entry.vj;
        s1B   <= issue.entry.useImm ? issue.entry.imm : issue.entry.vk;
        s1Tag <= issue.entry.tag;
    end

    assign shamt = s1B[4:0];

    always_comb begin
        case (s1Op)
            aluSub:  aluResult = s1A - s1B;
            aluAnd:  aluResult = s1A & s1B;
            aluOr:   aluResult = s1A | s1B;
            aluXor:  aluResult = s1A ^ s1B;
            aluSll:  aluResult = s1A << shamt;
            aluSrl:  aluResult = s1A >> shamt;
            aluSra:  aluResult = word_t'($signed(s1A) >>> shamt);
            aluSlt:  aluResult = word_t'($signed(s1A) < $signed(s1B));
            aluSltu: aluResult = word_t'(s1A < s1B);
            default: aluResult = s1A + s1B;
        endcase
    end

    // Writeback register, ROB never stalls
    always_ff @(posedge clk) begin
        if (rst || clr) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        wbTag   <= s1Tag;
        wbValue <= aluResult;
    end

    // Nothing in flight survives a flush, issue stage included
    assert property (@(posedge clk) (rst || clr) |=> !wbValid ##1 !wbValid);

endmodule

// File: src/reservationStation.sv
`timescale 1ns/1ns

module reservationStation (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   clr,
    // Dispatch
    input  logic                                   dispValid,
    output logic                                   dispAccept,
    input  rsPkg::rsOp_t                           dispOp,
    input  rsPkg::word_t                           dispVj,
    input  rsPkg::word_t                           dispVk,
    input  rsPkg::word_t                           dispImm,
    input  rsPkg::robTag_t                         dispQj,
    input  logic                                   dispQjWait,
    input  rsPkg::robTag_t                         dispQk,
    input  logic                                   dispQkWait,
    input  rsPkg::robTag_t                         dispTag,
    // ROB forwarding
    input  logic [rsPkg::ROB_ENTRIES-1:0]          robValid,
    input  rsPkg::word_t [rsPkg::ROB_ENTRIES-1:0]  robValue,
    // Writeback
    output logic                                   wbValid,
    output rsPkg::robTag_t                         wbTag,
    output rsPkg::word_t                           wbValue
);

    dispatchIf dispBus ();
    issueIf    issueBus ();

    rsDispatch i_rsDispatch (
        .clk        (clk),
        .rst        (rst),
        .clr        (clr),
        .dispValid  (dispValid),
        .dispOp     (dispOp),
        .dispVj     (dispVj),
        .dispVk     (dispVk),
        .dispImm    (dispImm),
        .dispQj     (dispQj),
        .dispQk     (dispQk),
        .dispTag    (dispTag),
        .dispQjWait (dispQjWait),
        .dispQkWait (dispQkWait),
        .dispAccept (dispAccept),
        .disp       (dispBus.producer)
    );

    rsEntryBank i_rsEntryBank (
        .clk      (clk),
        .rst      (rst),
        .clr      (clr),
        .robValid (robValid),
        .robValue (robValue),
        .disp     (dispBus.buffer),
        .issue    (issueBus.buffer)
    );

    rsIssueAlu i_rsIssueAlu (
        .clk     (clk),
        .rst     (rst),
        .clr     (clr),
        .issue   (issueBus.consumer),
        .wbValid (wbValid),
        .wbTag   (wbTag),
        .wbValue (wbValue)
    );

endmodule

// File: dv/tbReservationStation.sv
`timescale 1ns/1ns

module tbReservationStation;
    import rsPkg::*;

    localparam STIM_FILE = "dv/rsStimulus.txt";
    localparam int WAIT_LIMIT = 300;  // Cycles per wait loop
    localparam int SETTLE = 6;

    logic                    clk;
    logic                    rst;
    logic                    clr;
    logic                    dispValid;
    logic                    dispAccept;
    rsOp_t                   dispOp;
    word_t                   dispVj;
    word_t                   dispVk;
    word_t                   dispImm;
    robTag_t                 dispQj;
    logic                    dispQjWait;
    robTag_t                 dispQk;
    logic                    dispQkWait;
    robTag_t                 dispTag;
    logic [ROB_ENTRIES-1:0]  robValid;
    word_t [ROB_ENTRIES-1:0] robValue;
    logic                    wbValid;
    robTag_t                 wbTag;
    word_t                   wbValue;

    // Scoreboard, one slot per ROB tag
    logic [ROB_ENTRIES-1:0]  pending;
    logic [ROB_ENTRIES-1:0]  waitJ;
    logic [ROB_ENTRIES-1:0]  waitK;
    robTag_t                 srcJ [ROB_ENTRIES];
    robTag_t                 srcK [ROB_ENTRIES];
    word_t                   expVal [ROB_ENTRIES];
    int                      expLat [ROB_ENTRIES];
    int                      acceptCyc [ROB_ENTRIES];
    logic [ROB_ENTRIES-1:0]  robAtEdge = '0;
    int                      cycle = 0;
    int                      errors;
    int                      testErrors;
    int                      results;
    int                      testResults;
    int                      testsRun;
    integer                  seed;
    logic                    aborted;

    reservationStation i_reservationStation (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle     <= cycle + 1;
        robAtEdge <= robValid;  // ROB state seen by the DUT
    end

    task automatic noteError();
        errors++;
        testErrors++;
    endtask

    task automatic watchWriteback();
        forever begin
            @(negedge clk);
            if (wbValid) begin
                if (!pending[wbTag]) begin
                    $display("Unexpected writeback for ROB tag %0d at time %0t", wbTag, $time);
                    noteError();
                end else begin
                    if (wbValue !== expVal[wbTag]) begin
                        $display("error at %0t: tag %0d wrote %h, expected %h",
                                 $time, wbTag, wbValue, expVal[wbTag]);
                        noteError();
                    end
                    if (expLat[wbTag] != 0 && cycle - acceptCyc[wbTag] != expLat[wbTag]) begin
                        $display("error at %0t: tag %0d took %0d cycles, expected %0d",
                                 $time, wbTag, cycle - acceptCyc[wbTag], expLat[wbTag]);
                        noteError();
                    end
                    if ((waitJ[wbTag] && !robAtEdge[srcJ[wbTag]]) ||
                        (waitK[wbTag] && !robAtEdge[srcK[wbTag]])) begin
                        $display("Writeback for ROB tag %0d came before its source completed",
                                 wbTag);
                        noteError();
                    end
                    pending[wbTag] = 1'b0;
                    results++;
                    testResults++;
                end
            end
        end
    endtask

    task automatic dispatchOne(input logic [4:0] opCode, input word_t vj, input word_t vk,
                               input word_t imm, input logic wj, input robTag_t qj,
                               input logic wk, input robTag_t qk, input robTag_t tag,
                               input word_t expValue, input int lat);
        int gap;
        int waited;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(negedge clk);
        pending[tag] = 1'b1;
        expVal[tag]  = expValue;
        expLat[tag]  = lat;
        srcJ[tag]    = qj;
        srcK[tag]    = qk;
        waitJ[tag]   = wj && opCode != 5'h13;  // LUI reads no register
        waitK[tag]   = wk && opCode < 5'h0a;   // Immediate forms have no rs2
        dispOp       = rsOp_t'(opCode);
        dispVj       = vj;
        dispVk       = vk;
        dispImm      = imm;
        dispQjWait   = wj;
        dispQj       = qj;
        dispQkWait   = wk;
        dispQk       = qk;
        dispTag      = tag;
        dispValid    = 1'b1;
        waited = 0;
        while (!dispAccept && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!dispAccept) begin
            $display("Timed out waiting for dispAccept on ROB tag %0d", tag);
            aborted = 1'b1;
        end
        acceptCyc[tag] = cycle;
        @(negedge clk);
        dispValid = 1'b0;
    endtask

    task automatic completeRob(input robTag_t tag, input word_t value);
        robValue[tag] = value;
        robValid[tag] = 1'b1;
        @(negedge clk);
    endtask

    task automatic waitAccept(input logic level);
        int waited;
        waited = 0;
        while (dispAccept !== level && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (dispAccept !== level) begin
            $display("Timed out waiting for dispAccept to become %0b", level);
            aborted = 1'b1;
        end
    endtask

    task automatic flushStation();
        clr = 1'b1;
        @(negedge clk);
        clr = 1'b0;
        pending = '0;  // Flushed tags never write back
        if (!dispAccept) begin
            $display("error at %0t: dispAccept low right after clr", $time);
            noteError();
        end
    endtask

    task automatic finishTest(input logic [8*16-1:0] name);
        int waited;
        waited = 0;
        while (pending != '0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (pending != '0) begin
            $display("Timed out waiting for writebacks, tags %b still pending", pending);
            aborted = 1'b1;
        end
        repeat (SETTLE) @(negedge clk);  // Room for stray writebacks
        robValid = '0;
        $display("Test %0s finished: %0d writebacks, %0d errors", name, testResults, testErrors);
        testsRun++;
        testResults = 0;
        testErrors  = 0;
    endtask

    initial begin
        int               fd;
        int               n;
        int               lat;
        int               count;
        logic [8*256-1:0] line;
        logic [8*8-1:0]   kind;
        logic [8*16-1:0]  name;
        logic [4:0]       opCode;
        word_t            vj;
        word_t            vk;
        word_t            imm;
        word_t            expV;
        logic             wj;
        logic             wk;
        robTag_t          qj;
        robTag_t          qk;
        robTag_t          tag;

        seed        = 32'h780e3523;
        rst         = 1'b1;
        clr         = 1'b0;
        dispValid   = 1'b0;
        dispOp      = opAdd;
        dispVj      = '0;
        dispVk      = '0;
        dispImm     = '0;
        dispQj      = '0;
        dispQjWait  = 1'b0;
        dispQk      = '0;
        dispQkWait  = 1'b0;
        dispTag     = '0;
        robValid    = '0;
        robValue    = '0;
        pending     = '0;
        waitJ       = '0;
        waitK       = '0;
        errors      = 0;
        testErrors  = 0;
        results     = 0;
        testResults = 0;
        testsRun    = 0;
        aborted     = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // Idle station after reset
        repeat (4) begin
            @(negedge clk);
            if (wbValid || !dispAccept) begin
                $display("error at %0t: wbValid %0b dispAccept %0b after reset",
                         $time, wbValid, dispAccept);
                noteError();
            end
        end
        $display("Test reset finished: %0d errors", testErrors);
        testsRun++;
        testErrors = 0;

        fork
            watchWriteback();
        join_none

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open stimulus file %0s", STIM_FILE);
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            line = '0;
            kind = '0;
            n = $fgets(line, fd);
            n = $sscanf(line, "%s", kind);
            if (kind == "D") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %d", kind, opCode,
                            vj, vk, imm, wj, qj, wk, qk, tag, expV, lat);
                dispatchOne(opCode, vj, vk, imm, wj, qj, wk, qk, tag, expV, lat);
            end else if (kind == "R") begin
                n = $sscanf(line, "%s %h %h", kind, tag, vj);
                completeRob(tag, vj);
            end else if (kind == "W") begin
                n = $sscanf(line, "%s %d", kind, count);
                repeat (count) @(negedge clk);
            end else if (kind == "A") begin
                n = $sscanf(line, "%s %h", kind, wj);
                waitAccept(wj);
            end else if (kind == "C") begin
                flushStation();
            end else if (kind == "E") begin
                n = $sscanf(line, "%s %s", kind, name);
                finishTest(name);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("Tests %0d, writebacks %0d, errors %0d", testsRun, results, errors);
        if (errors == 0 && !aborted) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: dv/rsStimulus.txt
# D op vj vk imm qjWait qj qkWait qk tag expected latency(dec, 0 = unchecked) | R tag value
# W idle cycles | A dispAccept level | C flush | E test name; other fields hex
D 00 00000005 00000007 00000000 0 0 0 0 0 0000000c 4 add
D 01 00000003 00000005 00000000 0 0 0 0 1 fffffffe 4 sub
D 02 f0f0f0f0 0ff00ff0 00000000 0 0 0 0 2 00f000f0 4 and
D 03 f0f0f0f0 0ff00ff0 00000000 0 0 0 0 3 fff0fff0 4 or
D 04 f0f0f0f0 0ff00ff0 00000000 0 0 0 0 4 ff00ff00 4 xor
D 05 00000001 00000024 00000000 0 0 0 0 5 00000010 4 sll
D 06 80000000 00000004 00000000 0 0 0 0 6 08000000 4 srl
D 07 80000000 00000004 00000000 0 0 0 0 7 f8000000 4 sra
D 08 ffffffff 00000001 00000000 0 0 0 0 8 00000001 4 slt
D 09 ffffffff 00000001 00000000 0 0 0 0 9 00000000 4 sltu
E regreg
D 0a 00000010 deadbeef fffffffc 0 0 0 0 0 0000000c 4 addi
D 0b 12345678 deadbeef 000000ff 0 0 0 0 1 00000078 4 andi
D 0c 12345600 deadbeef 0000000f 0 0 0 0 2 1234560f 4 ori
D 0d 0000ffff deadbeef ffffffff 0 0 0 0 3 ffff0000 4 xori
D 0e 00000003 deadbeef 00000008 0 0 1 f 4 00000300 4 slli
D 0f f0000000 deadbeef 0000001c 0 0 0 0 5 0000000f 4 srli
D 10 f0000000 deadbeef 0000001c 0 0 0 0 6 ffffffff 4 srai
D 11 fffffff0 deadbeef fffffff1 0 0 0 0 7 00000001 4 slti
D 12 00000005 deadbeef ffffffff 0 0 0 0 8 00000001 4 sltiu
D 13 aaaaaaaa deadbeef 12345000 1 e 1 f 9 12345000 4 lui
E immediate
D 00 00000000 00000001 00000000 1 e 0 0 0 00000101 0 add
D 01 00001000 00000000 00000000 0 0 1 f 1 00000ff0 0 sub
D 04 00000000 00000000 00000000 1 e 1 f 2 00000110 0 xor
W 8
R e 00000100
W 4
R f 00000010
E wakeup
D 0a 00000000 00000000 00000000 1 f 0 0 0 00000100 0 addi
D 0a 00000000 00000000 00000001 1 f 0 0 1 00000101 0 addi
D 0a 00000000 00000000 00000002 1 f 0 0 2 00000102 0 addi
D 0a 00000000 00000000 00000003 1 f 0 0 3 00000103 0 addi
D 0a 00000000 00000000 00000004 1 f 0 0 4 00000104 0 addi
D 0a 00000000 00000000 00000005 1 f 0 0 5 00000105 0 addi
D 0a 00000000 00000000 00000006 1 f 0 0 6 00000106 0 addi
D 0a 00000000 00000000 00000007 1 f 0 0 7 00000107 0 addi
D 0a 00000000 00000000 00000008 1 f 0 0 8 00000108 0 addi
A 0
W 4
A 0
R f 00000100
A 1
E full
D 00 00000000 00000001 00000000 1 e 0 0 0 00000001 0 add
D 00 00000000 00000002 00000000 1 e 0 0 1 00000002 0 add
C
D 00 00000001 00000002 00000000 0 0 0 0 2 00000003 4 add
R e 00000050
W 8
E flush

// File: reservationStation.f
src/rsPkg.sv
src/rsIf.sv
src/rsDispatch.sv
src/rsEntryBank.sv
src/rsIssueAlu.sv
src/reservationStation.sv
dv/tbReservationStation.sv

// File: Makefile
TOP = tbReservationStation

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f reservationStation.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
